// File: verilog/mdu_config.svh
`ifndef MDU_CONFIG_SVH
`define MDU_CONFIG_SVH

// Operand and result width of the unit.
`define XLEN 32

// Divider step counter, must reach DIV_LAST.
`define DIV_CNT_W 6

// Counter value at which the divider answers.
`define DIV_LAST (`XLEN + 1)

`endif

// File: verilog/mdu_pkg.sv
`include "mdu_config.svh"

package mdu_pkg;

  typedef enum logic [2:0] {
    f3_mul    = 3'd0,
    f3_mulh   = 3'd1,
    f3_mulhsu = 3'd2,
    f3_mulhu  = 3'd3,
    f3_div    = 3'd4,
    f3_divu   = 3'd5,
    f3_rem    = 3'd6,
    f3_remu   = 3'd7
  } funct3_type;

  // One flag per operation, at most one set.
  typedef struct packed {
    logic mul;
    logic mulh;
    logic mulhsu;
    logic mulhu;
    logic divs;
    logic divu;
    logic rem;
    logic remu;
  } op_type;

  typedef struct packed {
    logic [`XLEN-1:0]      data1;
    logic [`XLEN-1:0]      data2;
    logic [`XLEN-1:0]      op1;      // Dividend magnitude.
    logic [`XLEN-1:0]      op2;      // Divisor magnitude.
    op_type                op;
    logic                  neg_quot;
    logic                  op1_neg;
    logic                  div_zero;
    logic                  overflow;
    logic [2*`XLEN:0]      result;   // Remainder high, quotient low.
    logic [`DIV_CNT_W-1:0] counter;
  } div_reg_type;

  localparam div_reg_type init_div_reg = '{
    data1:    '0,
    data2:    '0,
    op1:      '0,
    op2:      '0,
    op:       '0,
    neg_quot: 1'b0,
    op1_neg:  1'b0,
    div_zero: 1'b0,
    overflow: 1'b0,
    result:   '0,
    counter:  '0
  };

  typedef struct packed {
    logic [2*`XLEN+1:0] product;
    logic               high;
    logic               ready;
  } mul_reg_type;

  localparam mul_reg_type init_mul_reg = '{
    product: '0,
    high:    1'b0,
    ready:   1'b0
  };

endpackage

// File: verilog/mdu_if.sv
`timescale 1ns/100ps
`include "mdu_config.svh"

interface mdu_if;
  import mdu_pkg::*;

  logic             enable;
  op_type           op;
  logic [`XLEN-1:0] rdata1;
  logic [`XLEN-1:0] rdata2;
  logic [`XLEN-1:0] result;
  logic             ready;

  modport issuer (
    output enable, op, rdata1, rdata2,
    input  result, ready
  );

  modport unit (
    input  enable, op, rdata1, rdata2,
    output result, ready
  );

endinterface

// File: verilog/mdu_mul.sv
`timescale 1ns/100ps
`include "mdu_config.svh"

module mdu_mul (
  input logic  clk,
  input logic  rst,
  mdu_if.unit  bus
);
  import mdu_pkg::*;

  mul_reg_type  r;
  mul_reg_type  rin;
  logic         op1_signed;
  logic         op2_signed;
  logic [`XLEN:0] op_a;
  logic [`XLEN:0] op_b;

  always_comb begin
    op1_signed = bus.op.mulh | bus.op.mulhsu;
    op2_signed = bus.op.mulh;

    // One extra bit lets a single signed multiply cover all four forms.
    op_a = {op1_signed & bus.rdata1[`XLEN-1], bus.rdata1};
    op_b = {op2_signed & bus.rdata2[`XLEN-1], bus.rdata2};

    rin = r;
    rin.ready = bus.enable;
    if (bus.enable) begin
      rin.product = $signed(op_a) * $signed(op_b);
      rin.high = bus.op.mulh | bus.op.mulhsu | bus.op.mulhu;
    end
  end

  assign bus.ready = r.ready;
  assign bus.result = r.high ? r.product[2*`XLEN-1:`XLEN] :
                               r.product[`XLEN-1:0];

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      r <= init_mul_reg;
    end else begin
      r <= rin;
    end
  end

endmodule

// File: verilog/mdu_div.sv
`timescale 1ns/100ps
`include "mdu_config.svh"

module mdu_div (
  input logic  clk,
  input logic  rst,
  mdu_if.unit  bus
);
  import mdu_pkg::*;

  div_reg_type           r;
  div_reg_type           rin;
  div_reg_type           v;
  logic                  sign;
  logic [`DIV_CNT_W-1:0] lz;
  logic [2*`XLEN:0]      trial;
  logic [`XLEN:0]        diff;
  logic [`XLEN-1:0]      quot;
  logic [`XLEN-1:0]      remd;
  logic                  last;

  function automatic logic [`DIV_CNT_W-1:0] lead_zeros(input logic [`XLEN-1:0] x);
    logic [`DIV_CNT_W-1:0] n;
    logic                  found;
    n = '0;
    found = 1'b0;
    for (int i = `XLEN-1; i >= 0; i--) begin
      if (x[i]) begin
        found = 1'b1;
      end else if (!found) begin
        n = n + 1'b1;
      end
    end
    return n;
  endfunction

  assign last = (r.counter == `DIV_CNT_W'(`DIV_LAST));

  always_comb begin
    v = r;
    sign = bus.op.divs | bus.op.rem;
    lz = '0;
    trial = {r.result[2*`XLEN-1:0], 1'b0};
    diff = trial[2*`XLEN:`XLEN] - {1'b0, r.op2};

    if (r.counter == '0) begin
      if (bus.enable) begin
        v.data1 = bus.rdata1;
        v.data2 = bus.rdata2;
        v.op = bus.op;
        v.op1_neg = sign & bus.rdata1[`XLEN-1];
        v.neg_quot = sign & (bus.rdata1[`XLEN-1] ^ bus.rdata2[`XLEN-1]);
        v.op1 = v.op1_neg ? -bus.rdata1 : bus.rdata1;
        v.op2 = (sign & bus.rdata2[`XLEN-1]) ? -bus.rdata2 : bus.rdata2;
        v.div_zero = (bus.rdata2 == '0);
        v.overflow = sign & (bus.rdata1 == {1'b1, {(`XLEN-1){1'b0}}}) &
                     (&bus.rdata2);
        lz = lead_zeros(v.op1);
        v.result = {{(`XLEN+1){1'b0}}, v.op1} << lz;  // Skip leading zeros.
        if (v.div_zero | v.overflow) begin
          v.counter = `DIV_CNT_W'(`DIV_LAST);
        end else begin
          v.counter = lz + 1'b1;
        end
      end
    end else if (last) begin
      v.counter = '0;
    end else begin
      // Restore when the trial subtraction borrows.
      if (!diff[`XLEN]) begin
        v.result = {diff, trial[`XLEN-1:1], 1'b1};
      end else begin
        v.result = trial;
      end
      v.counter = r.counter + 1'b1;
    end

    rin = v;
  end

  always_comb begin
    quot = r.result[`XLEN-1:0];
    remd = r.result[2*`XLEN-1:`XLEN];
    if (r.neg_quot) begin
      quot = -quot;
    end
    if (r.op1_neg) begin
      remd = -remd;  // Remainder takes the dividend's sign.
    end

    bus.ready = last;
    bus.result = '0;
    if (last) begin
      if (r.op.divs | r.op.divu) begin
        if (r.div_zero) begin
          bus.result = '1;
        end else if (r.overflow) begin
          bus.result = {1'b1, {(`XLEN-1){1'b0}}};
        end else begin
          bus.result = quot;
        end
      end else begin
        if (r.div_zero) begin
          bus.result = r.data1;
        end else if (r.overflow) begin
          bus.result = '0;
        end else begin
          bus.result = remd;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      r <= init_div_reg;
    end else begin
      r <= rin;
    end
  end

  a_start_idle: assert property (@(posedge clk) disable iff (rst == 1'b0)
    bus.enable |-> r.counter == '0);

  a_rem_range: assert property (@(posedge clk) disable iff (rst == 1'b0)
    last && !r.div_zero && !r.overflow |-> r.result[2*`XLEN-1:`XLEN] < r.op2);

endmodule

// File: verilog/mdu_dispatch.sv
`timescale 1ns/100ps
`include "mdu_config.svh"

module mdu_dispatch (
  input  logic               clk,
  input  logic               rst,
  input  logic               enable,
  input  mdu_pkg::funct3_type funct3,
  input  logic [`XLEN-1:0]   rdata1,
  input  logic [`XLEN-1:0]   rdata2,
  output logic [`XLEN-1:0]   result,
  output logic               ready,
  output logic               busy,
  mdu_if.issuer              mul_bus,
  mdu_if.issuer              div_bus
);
  import mdu_pkg::*;

  op_type op;
  logic   is_div;

  always_comb begin
    op = '0;
    case (funct3)
      f3_mul:    op.mul = 1'b1;
      f3_mulh:   op.mulh = 1'b1;
      f3_mulhsu: op.mulhsu = 1'b1;
      f3_mulhu:  op.mulhu = 1'b1;
      f3_div:    op.divs = 1'b1;
      f3_divu:   op.divu = 1'b1;
      f3_rem:    op.rem = 1'b1;
      f3_remu:   op.remu = 1'b1;
      default:   op = '0;
    endcase
  end

  assign is_div = op.divs | op.divu | op.rem | op.remu;

  assign mul_bus.enable = enable & ~is_div;
  assign mul_bus.op = op;
  assign mul_bus.rdata1 = rdata1;
  assign mul_bus.rdata2 = rdata2;

  assign div_bus.enable = enable & is_div;
  assign div_bus.op = op;
  assign div_bus.rdata1 = rdata1;
  assign div_bus.rdata2 = rdata2;

  assign ready = mul_bus.ready | div_bus.ready;
  assign result = div_bus.ready ? div_bus.result : mul_bus.result;

  // High from the cycle after enable through the ready cycle.
  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      busy <= 1'b0;
    end else if (enable) begin
      busy <= 1'b1;
    end else if (ready) begin
      busy <= 1'b0;
    end
  end

  a_ready_excl: assert property (@(posedge clk) disable iff (rst == 1'b0)
    !(mul_bus.ready && div_bus.ready));

  a_no_issue_busy: assert property (@(posedge clk) disable iff (rst == 1'b0)
    busy |-> !enable);

endmodule

// File: verilog/mdu_top.sv
`timescale 1ns/100ps
`include "mdu_config.svh"

module mdu_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               enable,
  input  mdu_pkg::funct3_type funct3,
  input  logic [`XLEN-1:0]   rdata1,
  input  logic [`XLEN-1:0]   rdata2,
  output logic [`XLEN-1:0]   result,
  output logic               ready,
  output logic               busy
);

  mdu_if mul_bus ();
  mdu_if div_bus ();

  mdu_dispatch u_dispatch (
    .clk     (clk),
    .rst     (rst),
    .enable  (enable),
    .funct3  (funct3),
    .rdata1  (rdata1),
    .rdata2  (rdata2),
    .result  (result),
    .ready   (ready),
    .busy    (busy),
    .mul_bus (mul_bus.issuer),
    .div_bus (div_bus.issuer)
  );

  mdu_mul u_mul (
    .clk (clk),
    .rst (rst),
    .bus (mul_bus.unit)
  );

  mdu_div u_div (
    .clk (clk),
    .rst (rst),
    .bus (div_bus.unit)
  );

endmodule

// File: tests/mdu_tb.sv
`timescale 1ns/100ps
`include "mdu_config.svh"

module mdu_tb;
  import mdu_pkg::*;

  logic             clk;
  logic             rst;
  logic             enable;
  funct3_type       funct3;
  logic [`XLEN-1:0] rdata1;
  logic [`XLEN-1:0] rdata2;
  logic [`XLEN-1:0] result;
  logic             ready;
  logic             busy;

  logic [`XLEN-1:0] vec_funct3[$];
  logic [`XLEN-1:0] vec_op1[$];
  logic [`XLEN-1:0] vec_op2[$];
  logic [`XLEN-1:0] vec_expect[$];
  int               cycle_count;
  int               cycle_limit;

  mdu_top uut (
    .clk    (clk),
    .rst    (rst),
    .enable (enable),
    .funct3 (funct3),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .result (result),
    .ready  (ready),
    .busy   (busy)
  );

  always #20 clk = ~clk;

  task automatic abort_run();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input logic [`XLEN-1:0] actual,
                             input logic [`XLEN-1:0] expected, input string what);
    if (actual !== expected) begin
      $display("** Error at %0t: %s: got %h, expected %h", $time, what, actual, expected);
      abort_run();
    end
  endtask

  function automatic string op_name(input logic [2:0] f);
    case (f)
      3'd0: return "MUL";
      3'd1: return "MULH";
      3'd2: return "MULHSU";
      3'd3: return "MULHU";
      3'd4: return "DIV";
      3'd5: return "DIVU";
      3'd6: return "REM";
      default: return "REMU";
    endcase
  endfunction

  task automatic load_vectors();
    int               fd;
    int               n;
    string            line;
    logic [`XLEN-1:0] f;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] e;
    fd = $fopen("tests/mdu_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file tests/mdu_golden.txt");
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin  // Skip comments and blanks.
        n = $sscanf(line, "%h %h %h %h", f, a, b, e);
        if (n == 4) begin
          vec_funct3.push_back(f);
          vec_op1.push_back(a);
          vec_op2.push_back(b);
          vec_expect.push_back(e);
        end
      end
    end
    $fclose(fd);
    if (vec_op1.size() == 0) begin
      $display("The vector file holds no vectors");
      abort_run();
    end
  endtask

  task automatic run_vector(input int i, input int idle);
    logic [2:0] f3;
    string      name;
    int         lat;
    f3 = vec_funct3[i][2:0];
    name = op_name(f3);
    repeat (idle) begin
      @(posedge clk);
      @(negedge clk);
      check_value(`XLEN'(ready), '0, "ready while idle");
      check_value(`XLEN'(busy), '0, "busy while idle");
    end
    @(posedge clk);
    enable <= 1'b1;
    funct3 <= funct3_type'(f3);
    rdata1 <= vec_op1[i];
    rdata2 <= vec_op2[i];
    @(negedge clk);
    check_value(`XLEN'(ready), '0, $sformatf("%s ready in enable cycle", name));
    check_value(`XLEN'(busy), '0, $sformatf("%s busy in enable cycle", name));
    @(posedge clk);
    enable <= 1'b0;
    lat = 1;
    @(negedge clk);
    while (ready !== 1'b1) begin
      check_value(`XLEN'(busy), `XLEN'(1), $sformatf("%s busy while waiting", name));
      lat = lat + 1;
      if (lat > 33) begin
        $display("%s gave no ready within 33 cycles of its enable", name);
        abort_run();
      end
      @(negedge clk);
    end
    check_value(`XLEN'(busy), `XLEN'(1), $sformatf("%s busy in ready cycle", name));
    if (!f3[2]) begin
      check_value(`XLEN'(lat), `XLEN'(1), $sformatf("%s latency", name));  // Multiplies take one cycle.
    end
    check_value(result, vec_expect[i],
                $sformatf("%s %h, %h result", name, vec_op1[i], vec_op2[i]));
  endtask

  // Ends the run when the vectors take far longer than their worst case.
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, the vectors did not finish", cycle_count);
      abort_run();
    end
  end

  initial begin
    int idle;
    clk = 1'b0;
    rst = 1'b0;
    enable = 1'b0;
    funct3 = f3_mul;
    rdata1 = '0;
    rdata2 = '0;
    cycle_count = 0;
    void'($urandom(32'h51467675));
    load_vectors();
    cycle_limit = 10 + vec_op1.size() * 40;
    repeat (10) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    check_value(`XLEN'(ready), '0, "ready after reset");
    check_value(`XLEN'(busy), '0, "busy after reset");
    for (int i = 0; i < vec_op1.size(); i++) begin
      if (i >= vec_op1.size() - 4) begin
        idle = 0;  // The last vectors run back to back.
      end else begin
        idle = int'($urandom % 4);
      end
      run_vector(i, idle);
    end
    @(posedge clk);
    @(negedge clk);
    check_value(`XLEN'(ready), '0, "ready after last vector");
    check_value(`XLEN'(busy), '0, "busy after last vector");
    $display("sim passed");
    $finish;
  end

endmodule

// File: tests/mdu_golden.txt
# funct3 rdata1 rdata2 expected, all hex
# funct3 0..3 multiply forms, 4..7 DIV DIVU REM REMU; the last four run back to back
0 00000003 00000007 00000015
0 FFFFFFFF FFFFFFFF 00000001
0 12345678 00000010 23456780
0 80000000 00000002 00000000
0 FFFFFFFE 00000005 FFFFFFF6
1 FFFFFFFF FFFFFFFF 00000000
1 80000000 80000000 40000000
1 7FFFFFFF 7FFFFFFF 3FFFFFFF
1 FFFFFFFE 00000003 FFFFFFFF
1 80000000 7FFFFFFF C0000000
1 00010000 00010000 00000001
2 FFFFFFFF FFFFFFFF FFFFFFFF
2 00000002 FFFFFFFF 00000001
2 80000000 FFFFFFFF 80000000
2 7FFFFFFF 80000000 3FFFFFFF
3 FFFFFFFF FFFFFFFF FFFFFFFE
3 80000000 00000002 00000001
3 12345678 00000010 00000001
3 80000000 80000000 40000000
4 00000014 00000006 00000003
4 FFFFFFEC 00000006 FFFFFFFD
4 00000014 FFFFFFFA FFFFFFFD
4 FFFFFFEC FFFFFFFA 00000003
4 7FFFFFFF 00000001 7FFFFFFF
4 00000007 00000007 00000001
4 00000000 00000005 00000000
4 80000000 00000002 C0000000
5 FFFFFFFF 00000002 7FFFFFFF
5 80000000 FFFFFFFF 00000000
5 FFFFFFFE FFFFFFFF 00000000
5 FFFFFFFF FFFFFFFF 00000001
5 12345678 00001000 00012345
5 00000064 00000007 0000000E
6 00000014 00000006 00000002
6 FFFFFFEC 00000006 FFFFFFFE
6 00000014 FFFFFFFA 00000002
6 FFFFFFEC FFFFFFFA FFFFFFFE
6 80000001 00000003 FFFFFFFF
7 FFFFFFFF 00000002 00000001
7 00000064 00000007 00000002
7 12345678 00001000 00000678
7 00000003 FFFFFFFF 00000003
7 FFFFFFFF 0000000A 00000005
4 00001234 00000000 FFFFFFFF
5 80000000 00000000 FFFFFFFF
6 FFFFFF85 00000000 FFFFFF85
7 00ABCDEF 00000000 00ABCDEF
4 80000000 FFFFFFFF 80000000
6 80000000 FFFFFFFF 00000000
0 00000006 00000007 0000002A
5 00000064 0000000A 0000000A
3 FFFFFFFF 00000002 00000001
6 FFFFFFF9 00000002 FFFFFFFF

// File: all.f
+incdir+verilog
verilog/mdu_pkg.sv
verilog/mdu_if.sv
verilog/mdu_mul.sv
verilog/mdu_div.sv
verilog/mdu_dispatch.sv
verilog/mdu_top.sv
tests/mdu_tb.sv

// File: run.sh
#!/bin/bash
# Builds the MDU testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f all.f --top-module mdu_tb -o mdu_sim

output=$(./obj_dir/mdu_sim)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
  exit 0
else
  exit 1
fi
